// ==== abr_sampler.f ====
verilog/abr_sampler_pkg.sv
verilog/abr_mem_pkg.sv
verilog/sampler_ctrl.sv
verilog/rej_sampler.sv
verilog/sample_in_ball.sv
verilog/sib_mem_arbiter.sv
verilog/sib_mem.sv
verilog/abr_sampler_top.sv
test/abr_sampler_checker.sv
test/abr_sampler_tb.sv

// ==== test/abr_sampler_checker.sv ====
/*
  Protocol properties of abr_sampler_top, attached by bind.
  Properties are ignored while rst_b is low. Each failure also
  increments assert_fails, which the testbench reads at the end.
*/
`timescale 1ns/1ps
`default_nettype none

module abr_sampler_checker (
  input logic clk,
  input logic rst_b,
  input logic busy_i,
  input logic done_i,
  input logic ntt_dv_i,
  input logic word_hold_i,
  input logic ext_rd_en_i,
  input logic sib_grant_i
);

  int assert_fails = 0;

  dv_only_busy: assert property (@(posedge clk) disable iff (!rst_b) ntt_dv_i |-> busy_i)
    else begin
      $error("ntt_dv_o high while the sampler is idle");
      assert_fails++;
    end

  hold_only_busy: assert property (@(posedge clk) disable iff (!rst_b) !busy_i |-> !word_hold_i)
    else begin
      $error("word_hold_o high while the sampler is idle");
      assert_fails++;
    end

  // done is the last busy cycle
  idle_after_done: assert property (@(posedge clk) disable iff (!rst_b) done_i |=> !busy_i)
    else begin
      $error("busy_o still high on the cycle after done_o");
      assert_fails++;
    end

  ext_wins_port: assert property (@(posedge clk) disable iff (!rst_b)
                                  ext_rd_en_i |-> !sib_grant_i)
    else begin
      $error("sampler granted the memory while the external reader was enabled");
      assert_fails++;
    end

endmodule

bind abr_sampler_top abr_sampler_checker chk_inst (
  .clk         (clk),
  .rst_b       (rst_b),
  .busy_i      (busy_o),
  .done_i      (done_o),
  .ntt_dv_i    (ntt_dv_o),
  .word_hold_i (word_hold_o),
  .ext_rd_en_i (mem_rd_en_i),
  .sib_grant_i (sib_grant)
);

`default_nettype wire

// ==== test/abr_sampler_tb.sv ====
/*
  Testbench for abr_sampler_top with TAU = 39.
  Random words and read traffic come from $urandom, seeded once.
  Reads during a sample-in-ball run are checked against every memory state
  the model has passed through, as the DUT applies a placement over cycles.
  Runs in order: reset check, SIB, SIB with reads, rejection, SIB.
*/
`timescale 1ns/1ps
`default_nettype none

module abr_sampler_tb
  import abr_sampler_pkg::*;
  import abr_mem_pkg::*;
();

  localparam int TAU         = 39;
  localparam int I_FIRST     = 256 - TAU;
  localparam int RUN_CYCLES  = 2000;
  localparam int CYCLE_LIMIT = 4 * RUN_CYCLES + 5;

  logic                  clk;
  logic                  rst_b;
  logic                  start_i;
  sampler_mode_e         mode_i;
  logic                  word_valid_i;
  rand_word_u            word_i;
  logic                  word_hold_o;
  logic                  busy_o;
  logic                  done_o;
  logic                  ntt_dv_o;
  coeff_group_t          ntt_data_o;
  logic                  mem_rd_en_i;
  logic [MEM_ADDR_W-1:0] mem_rd_addr_i;
  logic [MEM_DATA_W-1:0] mem_rd_data_o;

  int                    val_errs;
  int                    misc_errs;
  int                    cyc;
  bit                    last_taken;

  // model state
  logic [Q_WIDTH-1:0]    acc_q[$];
  logic [MEM_DATA_W-1:0] model_mem[MEM_DEPTH];
  logic [MEM_DATA_W-1:0] snap[TAU+1][MEM_DEPTH];
  int                    snap_cnt;
  logic [63:0]           model_signs;
  int                    sign_cnt;
  int                    model_i;

  abr_sampler_top #(
    .TAU (TAU)
  ) uut (
    .clk           (clk),
    .rst_b         (rst_b),
    .start_i       (start_i),
    .mode_i        (mode_i),
    .word_valid_i  (word_valid_i),
    .word_i        (word_i),
    .word_hold_o   (word_hold_o),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .ntt_dv_o      (ntt_dv_o),
    .ntt_data_o    (ntt_data_o),
    .mem_rd_en_i   (mem_rd_en_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .mem_rd_data_o (mem_rd_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cyc = 0;
    while (cyc < CYCLE_LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    $display("ERROR timeout after %0d cycles, a run never finished", cyc);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
    val_errs++;
    $display("FAILED t=%0t %s expected %0h actual %0h", $time, name, exp, act);
  endtask

  task automatic report_problem(input string msg);
    misc_errs++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // inputs change 2 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // some candidates forced at or above q
  function automatic rand_word_u make_rej_word();
    rand_word_u  w;
    logic [23:0] c;
    for (int n = 0; n < 2; n++) begin
      c = 24'($urandom);
      case ($urandom_range(0, 3))
        0: c[22:12] = '1;
        1: c[22:0] = MLDSA_Q - 23'd1 + 23'($urandom_range(0, 2));
        default: ;
      endcase
      w.cand[n] = c;
    end
    return w;
  endfunction

  function automatic rand_word_u make_sib_word();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[WORD_W-1:0];
  endfunction

  function automatic logic [CODE_W-1:0] get_code(input int n);
    return model_mem[n / 4][CODE_W * (n % 4) +: CODE_W];
  endfunction

  task automatic set_code(input int n, input logic [CODE_W-1:0] code);
    model_mem[n / 4][CODE_W * (n % 4) +: CODE_W] = code;
  endtask

  task automatic clear_model();
    for (int a = 0; a < MEM_DEPTH; a++) begin
      model_mem[a] = '0;
      snap[0][a]   = '0;
    end
    snap_cnt    = 1;
    model_signs = '0;
    sign_cnt    = 0;
    model_i     = I_FIRST;
  endtask

  task automatic apply_rej_word(input rand_word_u w);
    logic [Q_WIDTH-1:0] c;
    for (int n = 0; n < 2; n++) begin
      c = w.cand[n][Q_WIDTH-1:0];
      if (c < MLDSA_Q) begin
        acc_q.push_back(c);
      end
    end
  endtask

  // bytes low first: 8 sign bytes, then one Fisher-Yates step per byte
  task automatic apply_sib_word(input rand_word_u w);
    int                bval;
    int                k;
    logic [CODE_W-1:0] old_j;
    for (int b = 0; b < WORD_W / 8; b++) begin
      bval = w.bytes[b];
      if (sign_cnt < 8) begin
        model_signs[8 * sign_cnt +: 8] = w.bytes[b];
        sign_cnt++;
      end else if (model_i <= 255 && bval <= model_i) begin
        k     = model_i - I_FIRST;
        old_j = get_code(bval);
        set_code(model_i, old_j);
        set_code(bval, model_signs[k] ? CODE_NEG : CODE_POS);
        model_i++;
        for (int a = 0; a < MEM_DEPTH; a++) begin
          snap[snap_cnt][a] = model_mem[a];
        end
        snap_cnt++;
      end
    end
  endtask

  // a word not yet taken stays on the bus unchanged
  task automatic drive_word(input bit sib);
    if (!word_valid_i || last_taken) begin
      if ($urandom_range(0, 3) == 0) begin
        word_valid_i = 1'b0;
      end else begin
        word_valid_i = 1'b1;
        word_i       = sib ? make_sib_word() : make_rej_word();
      end
    end
    last_taken = busy_o && word_valid_i && !word_hold_o;
    if (last_taken) begin
      if (sib) begin
        apply_sib_word(word_i);
      end else begin
        apply_rej_word(word_i);
      end
    end
  endtask

  task automatic start_run(input sampler_mode_e mode);
    start_i    = 1'b1;
    mode_i     = mode;
    last_taken = 1'b1;
    next_cycle();
    start_i = 1'b0;
    assert (busy_o) else report_mismatch("busy_o", 1, busy_o);
  endtask

  task automatic finish_run();
    word_valid_i = 1'b0;
    mem_rd_en_i  = 1'b0;
    next_cycle();
    assert (!busy_o) else report_mismatch("busy_o", 0, busy_o);
    assert (!done_o) else report_mismatch("done_o", 0, done_o);
  endtask

  task automatic read_and_compare(input bit count_codes);
    int                nz;
    logic [CODE_W-1:0] code;
    nz = 0;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      mem_rd_en_i   = 1'b1;
      mem_rd_addr_i = MEM_ADDR_W'(a);
      next_cycle();
      assert (mem_rd_data_o == model_mem[a])
        else report_mismatch($sformatf("mem_rd_data_o word %0d", a), model_mem[a], mem_rd_data_o);
      for (int p = 0; p < CODES_PER_WORD; p++) begin
        code = mem_rd_data_o[CODE_W * p +: CODE_W];
        if (code == 2'b10) begin
          report_problem($sformatf("illegal coefficient code in word %0d", a));
        end else if (code != CODE_ZERO) begin
          nz++;
        end
      end
    end
    mem_rd_en_i = 1'b0;
    if (count_codes) begin
      assert (nz == TAU) else report_mismatch("nonzero coefficient count", TAU, nz);
    end
  endtask

  task automatic run_rej();
    int grp;
    int idx;
    bit after_last;
    bit fin;
    acc_q.delete();
    grp        = 0;
    after_last = 1'b0;
    fin        = 1'b0;
    start_run(MODE_REJ);
    while (!fin) begin
      if (after_last) begin
        assert (done_o) else report_problem("done_o did not follow the 64th group");
      end
      after_last = 1'b0;
      if (ntt_dv_o) begin
        if (grp >= NUM_GROUPS) begin
          report_problem("ntt_dv_o pulsed after the last group");
        end else begin
          for (int p = 0; p < COEFF_PER_CLK; p++) begin
            idx = COEFF_PER_CLK * grp + p;
            if (idx >= acc_q.size()) begin
              report_problem("group emitted before its candidates were accepted");
            end else begin
              assert (ntt_data_o[p] == acc_q[idx])
                else report_mismatch($sformatf("ntt_data_o[%0d] group %0d", p, grp),
                                     acc_q[idx], ntt_data_o[p]);
            end
          end
        end
        grp++;
        after_last = (grp == NUM_GROUPS);
      end
      if (done_o) begin
        fin = 1'b1;
      end else begin
        drive_word(1'b0);
        next_cycle();
      end
    end
    assert (grp == NUM_GROUPS) else report_mismatch("ntt group count", NUM_GROUPS, grp);
    finish_run();
  endtask

  task automatic run_sib(input bit ext_reads);
    bit                    fin;
    bit                    rd_pend;
    bit                    hit;
    logic [MEM_ADDR_W-1:0] rd_addr;
    clear_model();
    fin     = 1'b0;
    rd_pend = 1'b0;
    rd_addr = '0;
    start_run(MODE_SIB);
    while (!fin) begin
      if (rd_pend) begin
        hit = 1'b0;
        for (int s = 0; s < snap_cnt; s++) begin
          if (snap[s][rd_addr] == mem_rd_data_o) begin
            hit = 1'b1;
          end
        end
        assert (hit)
          else report_problem($sformatf("read of word %0d returned %0h, never held by the model",
                                        rd_addr, mem_rd_data_o));
      end
      if (done_o) begin
        fin = 1'b1;
      end else begin
        drive_word(1'b1);
        if (ext_reads) begin
          rd_pend       = ($urandom_range(0, 2) == 0);
          rd_addr       = MEM_ADDR_W'($urandom_range(0, MEM_DEPTH - 1));
          mem_rd_en_i   = rd_pend;
          mem_rd_addr_i = rd_addr;
        end
        next_cycle();
      end
    end
    finish_run();
    read_and_compare(1'b1);
  endtask

  initial begin
    void'($urandom(46517));
    val_errs      = 0;
    misc_errs     = 0;
    rst_b         = 1'b0;
    start_i       = 1'b0;
    mode_i        = MODE_REJ;
    word_valid_i  = 1'b0;
    word_i        = '0;
    mem_rd_en_i   = 1'b0;
    mem_rd_addr_i = '0;
    clear_model();
    repeat (5) @(posedge clk);
    #2;
    rst_b = 1'b1;

    assert (!busy_o) else report_mismatch("busy_o", 0, busy_o);
    assert (!done_o) else report_mismatch("done_o", 0, done_o);
    assert (!ntt_dv_o) else report_mismatch("ntt_dv_o", 0, ntt_dv_o);
    assert (!word_hold_o) else report_mismatch("word_hold_o", 0, word_hold_o);
    read_and_compare(1'b0);

    run_sib(1'b0);
    run_sib(1'b1);
    run_rej();
    // memory keeps the last placement through a rejection run
    read_and_compare(1'b1);
    run_sib(1'b0);

    misc_errs += uut.chk_inst.assert_fails;
    $display("checks done: %0d value mismatches, %0d other errors", val_errs, misc_errs);
    if (val_errs == 0 && misc_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/abr_mem_pkg.sv ====
/*
  Geometry of the sample-in-ball coefficient memory.
  Coefficient n lives in word n/4 at bits 2*(n mod 4).
*/
`default_nettype none

package abr_mem_pkg;

  parameter int MEM_DEPTH      = 64;
  parameter int MEM_ADDR_W     = 6;
  parameter int CODE_W         = 2;
  parameter int CODES_PER_WORD = 4;
  parameter int MEM_DATA_W     = CODE_W * CODES_PER_WORD;

  parameter logic [CODE_W-1:0] CODE_ZERO = 2'b00;
  parameter logic [CODE_W-1:0] CODE_POS  = 2'b01;
  parameter logic [CODE_W-1:0] CODE_NEG  = 2'b11;

endpackage

`default_nettype wire

// ==== verilog/abr_sampler_pkg.sv ====
/*
  Algorithm constants and word types shared by the sampler blocks.
  An input word is 48 bits and is read either as two 24-bit rejection
  candidates or as six sample-in-ball bytes, lane/byte 0 in the low bits.
*/
`default_nettype none

package abr_sampler_pkg;

  parameter int Q_WIDTH       = 23;
  parameter int COEFF_PER_CLK = 4;
  parameter int NUM_GROUPS    = 64;
  parameter int WORD_W        = 48;

  parameter logic [Q_WIDTH-1:0] MLDSA_Q = 23'd8380417;

  typedef enum logic {
    MODE_REJ = 1'b0,
    MODE_SIB = 1'b1
  } sampler_mode_e;

  // same 48 bits, two readings
  typedef union packed {
    logic [1:0][WORD_W/2-1:0] cand;
    logic [WORD_W/8-1:0][7:0] bytes;
  } rand_word_u;

  // position 0 holds the oldest coefficient
  typedef logic [COEFF_PER_CLK-1:0][Q_WIDTH-1:0] coeff_group_t;

endpackage

`default_nettype wire

// ==== verilog/abr_sampler_top.sv ====
/*
  Polynomial sampler, rejection and sample-in-ball modes.
  Random words come from outside under a valid/hold handshake and are
  ignored while idle. The external memory reader always wins the port.
  TAU must not exceed 64.
*/
`timescale 1ns/1ps
`default_nettype none

module abr_sampler_top
  import abr_sampler_pkg::*;
  import abr_mem_pkg::*;
#(
  parameter int TAU = 39
) (
  input  logic                  clk,
  input  logic                  rst_b,
  input  logic                  start_i,
  input  sampler_mode_e         mode_i,
  input  logic                  word_valid_i,
  input  rand_word_u            word_i,
  output logic                  word_hold_o,
  output logic                  busy_o,
  output logic                  done_o,
  output logic                  ntt_dv_o,
  output coeff_group_t          ntt_data_o,
  input  logic                  mem_rd_en_i,
  input  logic [MEM_ADDR_W-1:0] mem_rd_addr_i,
  output logic [MEM_DATA_W-1:0] mem_rd_data_o
);

  logic                  rej_valid;
  logic                  sib_valid;
  logic                  sib_start;
  logic                  sib_hold;
  logic                  sib_done;
  logic                  sib_clear;
  logic                  sib_req;
  logic                  sib_we;
  logic [MEM_ADDR_W-1:0] sib_addr;
  logic [MEM_DATA_W-1:0] sib_wdata;
  logic                  sib_grant;
  logic                  mem_en;
  logic                  mem_we;
  logic [MEM_ADDR_W-1:0] mem_addr;
  logic [MEM_DATA_W-1:0] mem_wdata;

  sampler_ctrl ctrl_inst (
    .clk            (clk),
    .rst_b          (rst_b),
    .start_i        (start_i),
    .mode_i         (mode_i),
    .word_valid_i   (word_valid_i),
    .rej_group_dv_i (ntt_dv_o),
    .sib_hold_i     (sib_hold),
    .sib_done_i     (sib_done),
    .rej_valid_o    (rej_valid),
    .sib_valid_o    (sib_valid),
    .sib_start_o    (sib_start),
    .word_hold_o    (word_hold_o),
    .busy_o         (busy_o),
    .done_o         (done_o)
  );

  // packing buffer is flushed at the end of every run
  rej_sampler rej_inst (
    .clk        (clk),
    .rst_b      (rst_b),
    .start_i    (done_o),
    .valid_i    (rej_valid),
    .word_i     (word_i),
    .group_dv_o (ntt_dv_o),
    .group_o    (ntt_data_o)
  );

  sample_in_ball #(
    .TAU (TAU)
  ) sib_inst (
    .clk     (clk),
    .rst_b   (rst_b),
    .start_i (sib_start),
    .valid_i (sib_valid),
    .word_i  (word_i),
    .hold_o  (sib_hold),
    .done_o  (sib_done),
    .clear_o (sib_clear),
    .req_o   (sib_req),
    .we_o    (sib_we),
    .addr_o  (sib_addr),
    .wdata_o (sib_wdata),
    .grant_i (sib_grant),
    .rdata_i (mem_rd_data_o)
  );

  sib_mem_arbiter arb_inst (
    .ext_en_i    (mem_rd_en_i),
    .ext_addr_i  (mem_rd_addr_i),
    .sib_req_i   (sib_req),
    .sib_we_i    (sib_we),
    .sib_addr_i  (sib_addr),
    .sib_wdata_i (sib_wdata),
    .sib_grant_o (sib_grant),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata)
  );

  sib_mem mem_inst (
    .clk     (clk),
    .rst_b   (rst_b),
    .clear_i (sib_clear),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rd_data_o)
  );

endmodule

`default_nettype wire

// ==== verilog/rej_sampler.sv ====
/*
  Rejection sampler for q = 8380417. Each word gives two candidates,
  lane 0 first, each trimmed to 23 bits and kept when below q.
  At most one group of four leaves per word, so no input stall is needed.
*/
`timescale 1ns/1ps
`default_nettype none

module rej_sampler
  import abr_sampler_pkg::*;
(
  input  logic         clk,
  input  logic         rst_b,
  input  logic         start_i,
  input  logic         valid_i,
  input  rand_word_u   word_i,
  output logic         group_dv_o,
  output coeff_group_t group_o
);

  logic [COEFF_PER_CLK:0][Q_WIDTH-1:0] pend_q;
  logic [COEFF_PER_CLK:0][Q_WIDTH-1:0] pend_d;
  logic [2:0]                          cnt_q;
  logic [2:0]                          cnt_d;
  logic [1:0][Q_WIDTH-1:0]             cand;
  logic [1:0]                          acc;
  logic                                emit;

  always_comb begin
    pend_d = pend_q;
    cnt_d  = cnt_q;
    for (int n = 0; n < 2; n++) begin
      cand[n] = word_i.cand[n][Q_WIDTH-1:0];
      acc[n]  = (cand[n] < MLDSA_Q);
      if (valid_i && acc[n]) begin
        pend_d[cnt_d] = cand[n];
        cnt_d         = cnt_d + 3'd1;
      end
    end
  end

  assign emit = (cnt_d >= 3'(COEFF_PER_CLK));

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      cnt_q      <= '0;
      group_dv_o <= 1'b0;
    end else if (start_i) begin
      cnt_q      <= '0;
      group_dv_o <= 1'b0;
    end else begin
      group_dv_o <= emit;
      cnt_q      <= emit ? cnt_d - 3'(COEFF_PER_CLK) : cnt_d;
    end
  end

  // fifth slot carries over into the next group
  always_ff @(posedge clk) begin
    if (emit) begin
      group_o   <= pend_d[COEFF_PER_CLK-1:0];
      pend_q[0] <= pend_d[COEFF_PER_CLK];
    end else begin
      pend_q <= pend_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sample_in_ball.sv ====
/*
  Sample-in-ball. The first 8 bytes of a run are sign bits, later bytes
  drive the Fisher-Yates placement for i = 256-TAU .. 255.
  Memory access is request/grant and may stall any number of cycles.
  Read data is taken on the cycle after a granted read. TAU <= 64.
*/
`timescale 1ns/1ps
`default_nettype none

module sample_in_ball
  import abr_sampler_pkg::*;
  import abr_mem_pkg::*;
#(
  parameter int TAU = 39
) (
  input  logic                  clk,
  input  logic                  rst_b,
  input  logic                  start_i,
  input  logic                  valid_i,
  input  rand_word_u            word_i,
  output logic                  hold_o,
  output logic                  done_o,
  output logic                  clear_o,
  output logic                  req_o,
  output logic                  we_o,
  output logic [MEM_ADDR_W-1:0] addr_o,
  output logic [MEM_DATA_W-1:0] wdata_o,
  input  logic                  grant_i,
  input  logic [MEM_DATA_W-1:0] rdata_i
);

  localparam logic [7:0] I_FIRST   = 8'(256 - TAU);
  localparam logic [2:0] LAST_BYTE = 3'(WORD_W/8 - 1);
  localparam logic [2:0] ST_BYTE   = 3'd0;
  localparam logic [2:0] ST_RDJ    = 3'd1;
  localparam logic [2:0] ST_RDI    = 3'd2;
  localparam logic [2:0] ST_WRI    = 3'd3;
  localparam logic [2:0] ST_WRJ    = 3'd4;

  logic [2:0]            st_q;
  logic                  active_q;
  logic                  hold_q;
  logic                  rd_vld_q;
  rand_word_u            word_q;
  logic [2:0]            byte_idx;
  logic [3:0]            sign_cnt;
  logic [63:0]           signs;
  logic [7:0]            i_q;
  logic [7:0]            j_q;
  logic [MEM_DATA_W-1:0] jword_q;
  logic [MEM_DATA_W-1:0] iword_q;
  logic [MEM_DATA_W-1:0] iword;
  logic [MEM_DATA_W-1:0] wr_i;
  logic [MEM_DATA_W-1:0] wr_j;
  logic [7:0]            byte_cur;
  logic [5:0]            k_idx;
  logic [CODE_W-1:0]     sign_code;
  logic [CODE_W-1:0]     jcode_old;
  logic                  same_word;
  logic                  accept;
  logic                  sign_byte;
  logic                  reject;
  logic                  place;
  logic                  wr_fin;
  logic                  byte_done;

  assign byte_cur  = word_q.bytes[byte_idx];
  assign k_idx     = 6'(i_q - I_FIRST);
  assign sign_code = signs[k_idx] ? CODE_NEG : CODE_POS;
  assign same_word = (i_q[7:2] == j_q[7:2]);
  assign jcode_old = jword_q[CODE_W*j_q[1:0] +: CODE_W];
  assign iword     = rd_vld_q ? rdata_i : iword_q;

  assign accept    = (st_q == ST_BYTE) & ~hold_q & active_q & valid_i;
  assign sign_byte = (st_q == ST_BYTE) & hold_q & (sign_cnt != 4'd8);
  assign reject    = (st_q == ST_BYTE) & hold_q & (sign_cnt == 4'd8) & (byte_cur > i_q);
  assign place     = (st_q == ST_BYTE) & hold_q & (sign_cnt == 4'd8) & (byte_cur <= i_q);

  assign req_o   = active_q & (st_q != ST_BYTE);
  assign we_o    = (st_q == ST_WRI) | (st_q == ST_WRJ);
  assign addr_o  = ((st_q == ST_RDJ) | (st_q == ST_WRJ)) ? j_q[7:2] : i_q[7:2];
  assign wdata_o = (st_q == ST_WRJ) ? wr_j : wr_i;
  assign wr_fin  = req_o & grant_i & (((st_q == ST_WRI) & same_word) | (st_q == ST_WRJ));
  assign done_o  = wr_fin & (i_q == 8'd255);
  assign hold_o  = hold_q;
  assign clear_o = start_i;

  assign byte_done = sign_byte | reject | wr_fin;

  // c[i] takes the old c[j], then c[j] takes the sign
  always_comb begin
    wr_i = iword;
    wr_i[CODE_W*i_q[1:0] +: CODE_W] = jcode_old;
    if (same_word) begin
      wr_i[CODE_W*j_q[1:0] +: CODE_W] = sign_code;
    end
    wr_j = jword_q;
    wr_j[CODE_W*j_q[1:0] +: CODE_W] = sign_code;
  end

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      active_q <= 1'b0;
      hold_q   <= 1'b0;
      rd_vld_q <= 1'b0;
      st_q     <= ST_BYTE;
      byte_idx <= '0;
      sign_cnt <= '0;
      i_q      <= I_FIRST;
    end else if (start_i) begin
      active_q <= 1'b1;
      hold_q   <= 1'b0;
      rd_vld_q <= 1'b0;
      st_q     <= ST_BYTE;
      byte_idx <= '0;
      sign_cnt <= '0;
      i_q      <= I_FIRST;
    end else begin
      rd_vld_q <= req_o & grant_i & ~we_o;
      if (accept) begin
        hold_q   <= 1'b1;
        byte_idx <= '0;
      end
      if (sign_byte) begin
        sign_cnt <= sign_cnt + 4'd1;
      end
      if (byte_done) begin
        hold_q   <= (byte_idx != LAST_BYTE) & ~done_o;
        byte_idx <= (byte_idx == LAST_BYTE) ? 3'd0 : byte_idx + 3'd1;
      end
      if (wr_fin) begin
        i_q <= i_q + 8'd1;
      end
      if (done_o) begin
        active_q <= 1'b0;
      end
      unique case (st_q)
        ST_BYTE: if (place) st_q <= ST_RDJ;
        ST_RDJ:  if (grant_i) st_q <= ST_RDI;
        ST_RDI:  if (grant_i) st_q <= ST_WRI;
        ST_WRI:  if (grant_i) st_q <= same_word ? ST_BYTE : ST_WRJ;
        ST_WRJ:  if (grant_i) st_q <= ST_BYTE;
        default: st_q <= ST_BYTE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      word_q <= word_i;
    end
    if (sign_byte) begin
      signs[{sign_cnt[2:0], 3'b000} +: 8] <= byte_cur;
    end
    if (place) begin
      j_q <= byte_cur;
    end
    // first cycle after each granted read
    if ((st_q == ST_RDI) && rd_vld_q) begin
      jword_q <= rdata_i;
    end
    if ((st_q == ST_WRI) && rd_vld_q) begin
      iword_q <= rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sampler_ctrl.sv ====
/*
  Run controller. start_i is taken only while idle and latches the mode.
  Busy covers the run and the one-cycle done state.
*/
`timescale 1ns/1ps
`default_nettype none

module sampler_ctrl
  import abr_sampler_pkg::*;
(
  input  logic          clk,
  input  logic          rst_b,
  input  logic          start_i,
  input  sampler_mode_e mode_i,
  input  logic          word_valid_i,
  input  logic          rej_group_dv_i,
  input  logic          sib_hold_i,
  input  logic          sib_done_i,
  output logic          rej_valid_o,
  output logic          sib_valid_o,
  output logic          sib_start_o,
  output logic          word_hold_o,
  output logic          busy_o,
  output logic          done_o
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_RUN  = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;
  localparam int         GRP_W   = $clog2(NUM_GROUPS);

  logic [1:0]       st_q;
  sampler_mode_e    mode_q;
  logic [GRP_W-1:0] grp_cnt;
  logic             start;
  logic             run;
  logic             last_grp;
  logic             finish;

  assign start    = start_i & (st_q == ST_IDLE);
  assign run      = (st_q == ST_RUN);
  assign last_grp = rej_group_dv_i & (grp_cnt == GRP_W'(NUM_GROUPS - 1));
  assign finish   = (mode_q == MODE_REJ) ? last_grp : sib_done_i;

  // steer the handshake to the sampler of the latched mode
  assign rej_valid_o = run & (mode_q == MODE_REJ) & word_valid_i;
  assign sib_valid_o = run & (mode_q == MODE_SIB) & word_valid_i;
  assign word_hold_o = run & (mode_q == MODE_SIB) & sib_hold_i;
  assign sib_start_o = start & (mode_i == MODE_SIB);

  assign busy_o = (st_q != ST_IDLE);
  assign done_o = (st_q == ST_DONE);

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      st_q    <= ST_IDLE;
      mode_q  <= MODE_REJ;
      grp_cnt <= '0;
    end else begin
      unique case (st_q)
        ST_IDLE: begin
          if (start) begin
            st_q    <= ST_RUN;
            mode_q  <= mode_i;
            grp_cnt <= '0;
          end
        end
        ST_RUN: begin
          if (rej_group_dv_i) begin
            grp_cnt <= grp_cnt + 1'b1;
          end
          if (finish) begin
            st_q <= ST_DONE;
          end
        end
        default: begin
          st_q <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sib_mem.sv ====
/*
  64 x 8 register array, one access per cycle, read data one cycle later.
  Reset and clear zero every word in a single cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module sib_mem
  import abr_mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_b,
  input  logic                  clear_i,
  input  logic                  en_i,
  input  logic                  we_i,
  input  logic [MEM_ADDR_W-1:0] addr_i,
  input  logic [MEM_DATA_W-1:0] wdata_i,
  output logic [MEM_DATA_W-1:0] rdata_o
);

  logic [MEM_DEPTH-1:0][MEM_DATA_W-1:0] mem;

  always_ff @(posedge clk) begin
    if (!rst_b || clear_i) begin
      mem <= {MEM_DEPTH{ {CODES_PER_WORD{CODE_ZERO}} }};
    end else if (en_i && we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      rdata_o <= '0;
    end else if (en_i && !we_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sib_mem_arbiter.sv ====
/*
  Fixed-priority arbiter on the single memory port.
  The external reader is never refused; the sampler waits for grant.
*/
`timescale 1ns/1ps
`default_nettype none

module sib_mem_arbiter
  import abr_mem_pkg::*;
(
  input  logic                  ext_en_i,
  input  logic [MEM_ADDR_W-1:0] ext_addr_i,
  input  logic                  sib_req_i,
  input  logic                  sib_we_i,
  input  logic [MEM_ADDR_W-1:0] sib_addr_i,
  input  logic [MEM_DATA_W-1:0] sib_wdata_i,
  output logic                  sib_grant_o,
  output logic                  mem_en_o,
  output logic                  mem_we_o,
  output logic [MEM_ADDR_W-1:0] mem_addr_o,
  output logic [MEM_DATA_W-1:0] mem_wdata_o
);

  always_comb begin
    sib_grant_o = sib_req_i & ~ext_en_i;
    mem_en_o    = ext_en_i | sib_req_i;
    // external side only reads
    mem_we_o    = sib_grant_o & sib_we_i;
    mem_addr_o  = ext_en_i ? ext_addr_i : sib_addr_i;
    mem_wdata_o = sib_wdata_i;
  end

endmodule

`default_nettype wire
